// File: Makefile
# Verilator build and run for the Processer bus core

VERILATOR	?= verilator
FILELIST	?= Processer.f
TB_TOP		?= ProcesserTb
RTL_TOP		?= Processer
OBJ_DIR		?= obj_dir
VFLAGS		?= --binary --timing --assert -Wno-fatal
LINTFLAGS	?= --lint-only -Wall --timing
PASS_MSG	?= === PASS ===

SIM_BIN = $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output goes to the terminal, status comes from the pass search
run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: Processer.f
common/ProcesserPkg.sv
usi/UsiBusDecode.sv
usi/UsiReadReturn.sv
gpio/GpioRegBlock.sv
verilog/Processer.sv
sim/ProcesserTb.sv

// File: common/ProcesserPkg.sv
// Processer bus definitions
package ProcesserPkg;

	//----------------------------------------------------------
	// Bus widths
	//----------------------------------------------------------
	// Data path of the register bus
	localparam int lpUsiBusWidth	= 32;
	// Full register address
	localparam int lpBusAdrsBit		= 16;
	// Block number field, upper part of the address
	localparam int lpBlockAdrsMap	= 8;
	// Register offset field, whatever is left below the block number
	localparam int lpRegOfsBit		= lpBusAdrsBit - lpBlockAdrsMap;

	//----------------------------------------------------------
	// Address word
	//----------------------------------------------------------
	// One bus address seen two ways
	// Raw view as it arrives from a master
	// Map view split into block number and register offset
	typedef union packed {
		logic [lpBusAdrsBit-1:0] raw;
		struct packed {
			logic [lpBlockAdrsMap-1:0]	blk;
			logic [lpRegOfsBit-1:0]		ofs;
		} map;
	} UsiAdrs;

	//----------------------------------------------------------
	// GPIO register map
	//----------------------------------------------------------
	// Output latch load
	localparam logic [lpRegOfsBit-1:0] lpRegOut = 8'd0;
	// Bit set
	localparam logic [lpRegOfsBit-1:0] lpRegSet = 8'd1;
	// Bit clear
	localparam logic [lpRegOfsBit-1:0] lpRegClr = 8'd2;
	// Write counter, read only
	localparam logic [lpRegOfsBit-1:0] lpRegCnt = 8'd3;

	// Output latch width per block
	localparam int lpPortWidth		= 8;

	// First block number of the GPIO slaves
	localparam logic [lpBlockAdrsMap-1:0] lpBaseMapDefault = 8'h01;

endpackage

// File: gpio/GpioRegBlock.sv
// GPIO register slave
`timescale 1ns/1ps

module GpioRegBlock (
	input  logic									iSysClk,
	input  logic									rstN,
	// Broadcast bus
	input  logic [ProcesserPkg::lpUsiBusWidth-1:0]	busWd,
	input  logic [ProcesserPkg::lpRegOfsBit-1:0]	busOfs,
	// Strobes for this block only
	input  logic									wEd,
	input  logic									rEd,
	// Read answer, one cycle after rEd
	output logic [ProcesserPkg::lpUsiBusWidth-1:0]	rd,
	output logic									rVd,
	// Output latch
	output logic [ProcesserPkg::lpPortWidth-1:0]	portOut
);

import ProcesserPkg::*;

//----------------------------------------------------------
// Registers
//----------------------------------------------------------
// Accepted writes to offsets 0 to 2
logic [lpUsiBusWidth-1:0]	wrCnt;
// Write data cut to latch width
logic [lpPortWidth-1:0]		wrBits;
// Write lands on a counted register
logic						wrAcc;
// Next read word
logic [lpUsiBusWidth-1:0]	rdNext;

assign wrBits = busWd[lpPortWidth-1:0];

// Offset 3 and anything above is dropped
always_comb
begin
	case (busOfs)
		lpRegOut, lpRegSet, lpRegClr:	wrAcc = wEd;
		default:						wrAcc = 1'b0;
	endcase
end

//----------------------------------------------------------
// Latch and counter update
//----------------------------------------------------------
always_ff @(posedge iSysClk or negedge rstN)
begin
	if (!rstN)
	begin
		portOut	<= '0;
		wrCnt	<= '0;
	end
	else if (wrAcc)
	begin
		case (busOfs)
			// Plain load
			lpRegOut:	portOut <= wrBits;
			// Ones in the data set bits
			lpRegSet:	portOut <= portOut | wrBits;
			// Ones in the data clear bits
			default:	portOut <= portOut & ~wrBits;
		endcase
		wrCnt <= wrCnt + 1'b1;
	end
end

//----------------------------------------------------------
// Read path
//----------------------------------------------------------
// Offsets 0 to 2 all show the latch
always_comb
begin
	case (busOfs)
		lpRegOut, lpRegSet, lpRegClr:
		begin
			rdNext = {{(lpUsiBusWidth-lpPortWidth){1'b0}}, portOut};
		end
		lpRegCnt:
		begin
			rdNext = wrCnt;
		end
		default:
		begin
			rdNext = '0;
		end
	endcase
end

// Valid strobe
always_ff @(posedge iSysClk or negedge rstN)
begin
	if (!rstN)
	begin
		rVd <= 1'b0;
	end
	else
	begin
		rVd <= rEd;
	end
end

// Read word, only meaningful with rVd
always_ff @(posedge iSysClk)
begin
	if (rEd)
	begin
		rd <= rdNext;
	end
end

//----------------------------------------------------------
// Checks
//----------------------------------------------------------
// Decoder never reads and writes one block in the same cycle
assert property (@(posedge iSysClk) disable iff (!rstN) !(wEd && rEd))
	else $error("gpio read and write strobed together");

endmodule

// File: sim/ProcesserTb.sv
// Processer bus core testbench
`timescale 1ns/1ps

module ProcesserTb;

import ProcesserPkg::*;

localparam int lpSlaves		= 4;
localparam int lpDrainLimit	= 32;

logic						iSysClk;
logic						rstN;
logic						masterSel;
logic [lpUsiBusWidth-1:0]	mcbWd;
logic [lpBusAdrsBit-1:0]	mcbAdrs;
logic						mcbWEd;
logic						mcbREd;
logic [lpUsiBusWidth-1:0]	hostWd;
logic [lpBusAdrsBit-1:0]	hostAdrs;
logic						hostWEd;
logic						hostREd;
logic [lpUsiBusWidth-1:0]	rdData;
logic						rdValid;
logic [lpSlaves*lpPortWidth-1:0]	portOut;

//------------------------------------------------------------
// Reference model
//------------------------------------------------------------
// Latch and write counter per block
logic [lpSlaves-1:0][lpPortWidth-1:0]	modelPort;
logic [lpUsiBusWidth-1:0]				modelCnt [0:lpSlaves-1];
// Expected reads in issue order
logic [lpUsiBusWidth-1:0]				expMem [0:255];
int		wrPtr;
int		rdPtr = 0;
int		readCnt = 0;
int		errCnt;
int		testCnt;
int		testFail;
integer	seed;
// Strobes of whichever master owns the bus
logic	ownWr;
logic	ownRd;

assign ownWr = masterSel ? hostWEd : mcbWEd;
assign ownRd = masterSel ? hostREd : mcbREd;

Processer Processer_i (
	.masterSel	(masterSel),
	.mcbWd		(mcbWd),
	.mcbAdrs	(mcbAdrs),
	.mcbWEd		(mcbWEd),
	.mcbREd		(mcbREd),
	.hostWd		(hostWd),
	.hostAdrs	(hostAdrs),
	.hostWEd	(hostWEd),
	.hostREd	(hostREd),
	.rdData		(rdData),
	.rdValid	(rdValid),
	.portOut	(portOut),
	.iSysClk	(iSysClk),
	.rstN		(rstN)
);

initial
begin
	iSysClk = 1'b0;
	forever #10 iSysClk = ~iSysClk;
end

// Pop one expected value per returned read
always @(posedge iSysClk)
begin
	if (rstN && rdValid)
	begin
		rdPtr	<= rdPtr + 1;
		readCnt	<= readCnt + 1;
	end
end

//------------------------------------------------------------
// Checks
//------------------------------------------------------------
assert property (@(posedge iSysClk) disable iff (!rstN)
	rdValid |-> (rdPtr != wrPtr) && (rdData == expMem[rdPtr % 256]))
	else
	begin
		$display("mismatch %0t: read data %h, expected %h", $time,
			$sampled(rdData), expMem[$sampled(rdPtr) % 256]);
		errCnt++;
	end

// Read answered exactly two edges after its strobe
assert property (@(posedge iSysClk) disable iff (!rstN) $past(ownRd, 2) |-> rdValid)
	else
	begin
		$display("mismatch %0t: rdValid low two edges after a read", $time);
		errCnt++;
	end

assert property (@(posedge iSysClk) disable iff (!rstN) rdValid |-> $past(ownRd, 2))
	else
	begin
		$display("mismatch %0t: rdValid without a read two edges before", $time);
		errCnt++;
	end

// Latches against model two edges after a write
assert property (@(posedge iSysClk) disable iff (!rstN)
	$past(ownWr, 2) |-> portOut == $past(modelPort, 2))
	else
	begin
		$display("mismatch %0t: portOut %h, expected %h", $time,
			$sampled(portOut), $past(modelPort, 2));
		errCnt++;
	end

//------------------------------------------------------------
// Stimulus helpers
//------------------------------------------------------------
function automatic logic [lpBusAdrsBit-1:0] adrsOf(input int k, input logic [7:0] ofs);
	adrsOf = {lpBaseMapDefault + 8'(k), ofs};
endfunction

function automatic logic [7:0] pickOfs(input int span);
	pickOfs = 8'($unsigned($random(seed)) % span);
endfunction

function automatic logic [lpUsiBusWidth-1:0] pickData();
	pickData = $random(seed);
endfunction

// Loads or sets or clears, reads push the expected word
task automatic modelCmd(input logic wr, input logic [15:0] adrs, input logic [31:0] data);
	UsiAdrs						a;
	int							idx;
	logic [lpUsiBusWidth-1:0]	exp;
	a.raw	= adrs;
	idx		= int'(a.map.blk) - int'(lpBaseMapDefault);
	exp		= '0;
	if (wr && idx >= 0 && idx < lpSlaves && a.map.ofs < lpRegCnt)
	begin
		case (a.map.ofs)
			lpRegOut:	modelPort[idx] = data[7:0];
			lpRegSet:	modelPort[idx] = modelPort[idx] | data[7:0];
			default:	modelPort[idx] = modelPort[idx] & ~data[7:0];
		endcase
		modelCnt[idx] = modelCnt[idx] + 32'd1;
	end
	else if (!wr)
	begin
		if (idx >= 0 && idx < lpSlaves && a.map.ofs < lpRegCnt)
			exp = {24'd0, modelPort[idx]};
		else if (idx >= 0 && idx < lpSlaves && a.map.ofs == lpRegCnt)
			exp = modelCnt[idx];
		expMem[wrPtr % 256] = exp;
		wrPtr++;
	end
endtask

task automatic clearStrobes();
	mcbWEd	= 1'b0;
	mcbREd	= 1'b0;
	hostWEd	= 1'b0;
	hostREd	= 1'b0;
endtask

task automatic driveMcb(input logic wr, input logic [15:0] adrs, input logic [31:0] data);
	mcbAdrs	= adrs;
	mcbWd	= data;
	mcbWEd	= wr;
	mcbREd	= !wr;
endtask

task automatic driveHost(input logic wr, input logic [15:0] adrs, input logic [31:0] data);
	hostAdrs	= adrs;
	hostWd		= data;
	hostWEd		= wr;
	hostREd		= !wr;
endtask

// One master strobes, model follows only the owner
task automatic sendCmd(input logic host, input logic wr, input logic [15:0] adrs,
		input logic [31:0] data);
	@(negedge iSysClk);
	clearStrobes();
	if (host)
		driveHost(wr, adrs, data);
	else
		driveMcb(wr, adrs, data);
	if (host == masterSel)
		modelCmd(wr, adrs, data);
endtask

// Owner and the idle master strobe in the same cycle
task automatic sendDual(input logic wr, input logic [15:0] adrs, input logic [31:0] data,
		input logic otherWr, input logic [15:0] otherAdrs, input logic [31:0] otherData);
	@(negedge iSysClk);
	if (masterSel)
	begin
		driveHost(wr, adrs, data);
		driveMcb(otherWr, otherAdrs, otherData);
	end
	else
	begin
		driveMcb(wr, adrs, data);
		driveHost(otherWr, otherAdrs, otherData);
	end
	modelCmd(wr, adrs, data);
endtask

task automatic idleCycle();
	@(negedge iSysClk);
	clearStrobes();
endtask

task automatic setOwner(input logic host);
	@(negedge iSysClk);
	clearStrobes();
	masterSel = host;
endtask

// Bus quiet, then every pushed read must come back
task automatic waitDrain(input string what);
	int n;
	idleCycle();
	n = 0;
	while (rdPtr != wrPtr && n < lpDrainLimit)
	begin
		@(posedge iSysClk);
		n++;
	end
	if (rdPtr != wrPtr)
	begin
		$display("timeout: reads of %s did not return within %0d cycles", what, lpDrainLimit);
		errCnt++;
		wrPtr = rdPtr;
	end
endtask

task automatic endTest(input int num, input string name, input int errBefore);
	testCnt++;
	if (errCnt == errBefore)
		$display("test %0d %s: ok", num, name);
	else
	begin
		testFail++;
		$display("test %0d %s: failed with %0d errors", num, name, errCnt - errBefore);
	end
endtask

//------------------------------------------------------------
// Test sequence
//------------------------------------------------------------
initial
begin
	int e;
	int i;
	int k;
	seed = 32'h2adcfffa;
	rstN = 1'b0;
	masterSel = 1'b0;
	mcbWd = '0;
	mcbAdrs = '0;
	hostWd = '0;
	hostAdrs = '0;
	clearStrobes();
	modelPort = '0;
	for (k = 0; k < lpSlaves; k++)
		modelCnt[k] = '0;
	wrPtr = 0;
	errCnt = 0;
	testCnt = 0;
	testFail = 0;
	repeat (3) @(posedge iSysClk);
	@(negedge iSysClk);
	rstN = 1'b1;

	// Everything zero out of reset
	e = errCnt;
	assert (portOut == '0)
		else
		begin
			$display("mismatch %0t: portOut %h after reset", $time, portOut);
			errCnt++;
		end
	for (k = 0; k < lpSlaves; k++)
	begin
		sendCmd(1'b0, 1'b0, adrsOf(k, lpRegOut), '0);
		sendCmd(1'b0, 1'b0, adrsOf(k, lpRegCnt), '0);
	end
	waitDrain("reset values");
	endTest(1, "reset", e);

	// Load, set, clear with read-back right behind
	e = errCnt;
	for (k = 0; k < lpSlaves; k++)
		for (i = 0; i < 6; i++)
		begin
			sendCmd(1'b0, 1'b1, adrsOf(k, pickOfs(3)), pickData());
			sendCmd(1'b0, 1'b0, adrsOf(k, pickOfs(3)), '0);
		end
	waitDrain("latch read-back");
	endTest(2, "latch set clear", e);

	// Counter skips offset 3 and unmapped writes
	e = errCnt;
	for (k = 0; k < lpSlaves; k++)
	begin
		sendCmd(1'b0, 1'b0, adrsOf(k, lpRegCnt), '0);
		sendCmd(1'b0, 1'b1, adrsOf(k, lpRegCnt), pickData());
	end
	sendCmd(1'b0, 1'b1, 16'h0000, pickData());
	sendCmd(1'b0, 1'b1, 16'h0501, pickData());
	for (k = 0; k < lpSlaves; k++)
		for (i = 0; i <= k; i++)
			sendCmd(1'b0, 1'b1, adrsOf(k, lpRegOut), pickData());
	for (k = 0; k < lpSlaves; k++)
		sendCmd(1'b0, 1'b0, adrsOf(k, lpRegCnt), '0);
	waitDrain("write counters");
	endTest(3, "write counter", e);

	// Host owns the bus, mcb strobes are noise
	e = errCnt;
	setOwner(1'b1);
	for (k = 0; k < lpSlaves; k++)
	begin
		sendDual(1'b1, adrsOf(k, lpRegOut), pickData(), 1'b1, adrsOf(k, lpRegOut), pickData());
		sendDual(1'b0, adrsOf(k, lpRegOut), '0, 1'b1, adrsOf(k, lpRegSet), pickData());
		sendDual(1'b1, adrsOf(k, lpRegClr), pickData(), 1'b0, adrsOf(k, lpRegCnt), '0);
		sendCmd(1'b0, 1'b0, adrsOf(k, lpRegOut), '0);
	end
	waitDrain("host commands");
	setOwner(1'b0);
	for (k = 0; k < lpSlaves; k++)
	begin
		sendDual(1'b1, adrsOf(k, lpRegSet), pickData(), 1'b1, adrsOf(k, lpRegOut), pickData());
		sendDual(1'b0, adrsOf(k, lpRegOut), '0, 1'b0, adrsOf(k, lpRegCnt), '0);
	end
	waitDrain("mcb after switch back");
	endTest(4, "master select", e);

	// Unmapped blocks read zero, then a dense read burst
	e = errCnt;
	sendCmd(1'b0, 1'b0, 16'h0000, '0);
	sendCmd(1'b0, 1'b0, {8'h05, lpRegCnt}, '0);
	for (i = 0; i < 16; i++)
		sendCmd(1'b0, 1'b0, adrsOf(i % lpSlaves, pickOfs(5)), '0);
	waitDrain("pipelined reads");
	endTest(5, "unmapped and pipelined reads", e);

	$display("tests %0d, failed %0d, reads checked %0d, errors %0d",
		testCnt, testFail, readCnt, errCnt);
	if (errCnt == 0)
		$display("=== PASS ===");
	else
		$display("=== FAIL ===");
	$finish;
end

endmodule

// File: usi/UsiBusDecode.sv
// USI bus master select and decode
`timescale 1ns/1ps

module UsiBusDecode #(
	parameter int pSlaveNum = 4,
	parameter logic [ProcesserPkg::lpBlockAdrsMap-1:0] pBaseMap = ProcesserPkg::lpBaseMapDefault
)(
	input  logic									iSysClk,
	input  logic									rstN,
	// Bus owner
	input  logic									masterSel,
	// Controller command
	input  logic [ProcesserPkg::lpUsiBusWidth-1:0]	mcbWd,
	input  logic [ProcesserPkg::lpBusAdrsBit-1:0]	mcbAdrs,
	input  logic									mcbWEd,
	input  logic									mcbREd,
	// Host command
	input  logic [ProcesserPkg::lpUsiBusWidth-1:0]	hostWd,
	input  logic [ProcesserPkg::lpBusAdrsBit-1:0]	hostAdrs,
	input  logic									hostWEd,
	input  logic									hostREd,
	// Slave side
	output logic [ProcesserPkg::lpUsiBusWidth-1:0]	busWd,
	output logic [ProcesserPkg::lpRegOfsBit-1:0]	busOfs,
	output logic [pSlaveNum-1:0]					slvWEd,
	output logic [pSlaveNum-1:0]					slvREd,
	output logic									missREd
);

import ProcesserPkg::*;

//----------------------------------------------------------
// Command mux
//----------------------------------------------------------
logic [lpUsiBusWidth-1:0]	selWd;
UsiAdrs						selAdrs;
logic						selWEd;
logic						selREd;
// Block number relative to the first slave
logic [lpBlockAdrsMap-1:0]	slvIdx;
logic						hit;
logic [pSlaveNum-1:0]		oneHot;
// Miss held back one cycle to line up with slave read data
logic						missPend;

always_comb
begin
	// Idle master strobes are simply not looked at
	selWd		= masterSel ? hostWd   : mcbWd;
	selAdrs.raw	= masterSel ? hostAdrs : mcbAdrs;
	selWEd		= masterSel ? hostWEd  : mcbWEd;
	selREd		= masterSel ? hostREd  : mcbREd;
	// Range test from pBaseMap up to pBaseMap+pSlaveNum-1
	slvIdx		= selAdrs.map.blk - pBaseMap;
	hit			= (selAdrs.map.blk >= pBaseMap) && (slvIdx < pSlaveNum);
	for (int k = 0; k < pSlaveNum; k++)
	begin
		oneHot[k] = hit && (slvIdx == k);
	end
end

//----------------------------------------------------------
// Strobe registers
//----------------------------------------------------------
always_ff @(posedge iSysClk or negedge rstN)
begin
	if (!rstN)
	begin
		slvWEd		<= '0;
		slvREd		<= '0;
		missPend	<= 1'b0;
		missREd		<= 1'b0;
	end
	else
	begin
		// Unmapped writes fall out here since oneHot is zero
		slvWEd		<= selWEd ? oneHot : '0;
		slvREd		<= selREd ? oneHot : '0;
		missPend	<= selREd && !hit;
		missREd		<= missPend;
	end
end

// Payload follows any command
always_ff @(posedge iSysClk)
begin
	if (selWEd || selREd)
	begin
		busWd	<= selWd;
		busOfs	<= selAdrs.map.ofs;
	end
end

//----------------------------------------------------------
// Checks
//----------------------------------------------------------
// At most one slave strobed, never read and write together
assert property (@(posedge iSysClk) disable iff (!rstN)
	$onehot0(slvWEd) && $onehot0(slvREd) && !((|slvWEd) && (|slvREd)))
	else $error("decode strobe not one-hot");

endmodule

// File: usi/UsiReadReturn.sv
// USI bus read data return
`timescale 1ns/1ps

module UsiReadReturn #(
	parameter int pSlaveNum = 4
)(
	// Slave k data in word k
	input  logic [pSlaveNum*ProcesserPkg::lpUsiBusWidth-1:0]	slvRd,
	// One-hot slave valids
	input  logic [pSlaveNum-1:0]								slvRVd,
	// Read of an unmapped block
	input  logic												missREd,
	// Back to the master
	output logic [ProcesserPkg::lpUsiBusWidth-1:0]				rdData,
	output logic												rdValid
);

import ProcesserPkg::*;

//----------------------------------------------------------
// Read data select
//----------------------------------------------------------
// AND-OR mux, valids are one-hot
// Miss leaves every term gated off so data is zero
always_comb
begin
	rdData = '0;
	for (int k = 0; k < pSlaveNum; k++)
	begin
		if (slvRVd[k])
		begin
			rdData = rdData | slvRd[k*lpUsiBusWidth +: lpUsiBusWidth];
		end
	end
end

// Any slave answer or a miss
assign rdValid = (|slvRVd) || missREd;

//----------------------------------------------------------
// Checks
//----------------------------------------------------------
// Combinational block without a clock
// Deferred check so settling bits are not flagged
always_comb
begin
	assert final ($onehot0(slvRVd))
		else $error("slave read valids not one-hot");
	assert final (!(missREd && (|slvRVd)))
		else $error("miss collides with slave read");
end

endmodule

// File: verilog/Processer.sv
// Processer bus core top
`timescale 1ns/1ps

module Processer #(
	parameter int pSlaveNum = 4,
	parameter logic [ProcesserPkg::lpBlockAdrsMap-1:0] pBaseMap = ProcesserPkg::lpBaseMapDefault
)(
	// Owner select, 0 mcb and 1 host
	input  logic										masterSel,
	// On-chip controller port
	input  logic [ProcesserPkg::lpUsiBusWidth-1:0]		mcbWd,
	input  logic [ProcesserPkg::lpBusAdrsBit-1:0]		mcbAdrs,
	input  logic										mcbWEd,
	input  logic										mcbREd,
	// External host port
	input  logic [ProcesserPkg::lpUsiBusWidth-1:0]		hostWd,
	input  logic [ProcesserPkg::lpBusAdrsBit-1:0]		hostAdrs,
	input  logic										hostWEd,
	input  logic										hostREd,
	// Read return
	output logic [ProcesserPkg::lpUsiBusWidth-1:0]		rdData,
	output logic										rdValid,
	// GPIO latches, slave k in byte k
	output logic [pSlaveNum*ProcesserPkg::lpPortWidth-1:0]	portOut,
	// Clk Rst
	input  logic										iSysClk,
	input  logic										rstN
);

import ProcesserPkg::*;

//----------------------------------------------------------
// Bus wires
//----------------------------------------------------------
// Broadcast to every slave
logic [lpUsiBusWidth-1:0]			busWd;
logic [lpRegOfsBit-1:0]				busOfs;
// Per-slave strobes, one-hot
logic [pSlaveNum-1:0]				slvWEd;
logic [pSlaveNum-1:0]				slvREd;
// Unmapped read marker
logic								missREd;
// Slave read data and valids
logic [pSlaveNum*lpUsiBusWidth-1:0]	slvRd;
logic [pSlaveNum-1:0]				slvRVd;

//----------------------------------------------------------
// Master select and block decode
//----------------------------------------------------------
UsiBusDecode #(
	.pSlaveNum	(pSlaveNum),
	.pBaseMap	(pBaseMap)
) USI_BUS_DECODE (
	.iSysClk	(iSysClk),
	.rstN		(rstN),
	.masterSel	(masterSel),
	.mcbWd		(mcbWd),
	.mcbAdrs	(mcbAdrs),
	.mcbWEd		(mcbWEd),
	.mcbREd		(mcbREd),
	.hostWd		(hostWd),
	.hostAdrs	(hostAdrs),
	.hostWEd	(hostWEd),
	.hostREd	(hostREd),
	.busWd		(busWd),
	.busOfs		(busOfs),
	.slvWEd		(slvWEd),
	.slvREd		(slvREd),
	.missREd	(missREd)
);

//----------------------------------------------------------
// GPIO register slaves
//----------------------------------------------------------
for (genvar k = 0; k < pSlaveNum; k++)
begin : gGpio
	GpioRegBlock GPIO_REG_BLOCK (
		.iSysClk	(iSysClk),
		.rstN		(rstN),
		.busWd		(busWd),
		.busOfs		(busOfs),
		.wEd		(slvWEd[k]),
		.rEd		(slvREd[k]),
		.rd			(slvRd[k*lpUsiBusWidth +: lpUsiBusWidth]),
		.rVd		(slvRVd[k]),
		.portOut	(portOut[k*lpPortWidth +: lpPortWidth])
	);
end

//----------------------------------------------------------
// Read data return
//----------------------------------------------------------
UsiReadReturn #(
	.pSlaveNum	(pSlaveNum)
) USI_READ_RETURN (
	.slvRd		(slvRd),
	.slvRVd		(slvRVd),
	.missREd	(missREd),
	.rdData		(rdData),
	.rdValid	(rdValid)
);

endmodule
